// ==== logic/vmask_cfg_pkg.sv ====
`default_nettype none

// ======================================================================
// Vector configuration widths
// ======================================================================

package vmask_cfg_pkg;

	// Bytes in one vector register
	// Every mask has one bit for each of these byte positions
	localparam int VEC_BYTES = 64;

	// Lane counts run from 0 to VEC_BYTES inclusive, so one extra bit is needed
	localparam int LANE_CNT_W = $clog2(VEC_BYTES) + 1;

	// Element size is stored as log2 of its byte count: 1, 2, 4 or 8 bytes
	localparam int ESZ_W = 2;

	// Index width of the mask register file
	localparam int MREG_IDX_W = 3;

	// One bit per byte position of a vector register
	typedef logic [VEC_BYTES-1:0] mask_t;

	// Count of lanes, or of set bits in a mask
	typedef logic [LANE_CNT_W-1:0] lane_cnt_t;

	// Element size code, 0 means bytes and 3 means 8-byte elements
	typedef logic [ESZ_W-1:0] esz_t;

	// Mask register number
	typedef logic [MREG_IDX_W-1:0] mreg_idx_t;

endpackage

`default_nettype wire

// ==== logic/vmask_op_pkg.sv ====
`default_nettype none

// ======================================================================
// Operation encoding and the request / response records
// ======================================================================

package vmask_op_pkg;

	// Operation code as issued by the back end
	typedef logic [2:0] opcode_t;

	// Clamp a requested length and store the configuration
	localparam opcode_t OP_SETVL    = 3'd0;
	// Build a lane mask from the stored configuration
	localparam opcode_t OP_SETVMASK = 3'd1;
	// Mask combines, rd = rs1 op rs2
	localparam opcode_t OP_MAND     = 3'd2;
	localparam opcode_t OP_MOR      = 3'd3;
	localparam opcode_t OP_MXOR     = 3'd4;
	localparam opcode_t OP_MANDN    = 3'd5;
	// Count the set bits of rs1
	localparam opcode_t OP_MPOP     = 3'd6;
	// Code 3'd7 is not assigned and completes with an empty result

	// One operation, sampled on every clock edge when valid is high
	typedef struct packed {
		logic                      valid;
		opcode_t                   opcode;
		vmask_cfg_pkg::mreg_idx_t  rd;
		vmask_cfg_pkg::mreg_idx_t  rs1;
		vmask_cfg_pkg::mreg_idx_t  rs2;
		vmask_cfg_pkg::esz_t       esz;
		vmask_cfg_pkg::lane_cnt_t  req_len;
	} op_t;

	// Registered result, present for one cycle after the operation
	// The mask field carries data for mask writers and count for SETVL and MPOP
	typedef struct packed {
		logic                      valid;
		opcode_t                   opcode;
		vmask_cfg_pkg::mask_t      mask;
		vmask_cfg_pkg::lane_cnt_t  count;
	} res_t;

endpackage

`default_nettype wire

// ==== logic/vlen_calc.sv ====
`timescale 1ns/100ps
`default_nettype none

// ======================================================================
// Vector length clamp
// ======================================================================

module vlen_calc (
	input  vmask_cfg_pkg::esz_t      esz,
	input  vmask_cfg_pkg::lane_cnt_t req_len,
	output vmask_cfg_pkg::lane_cnt_t max_lanes,
	output vmask_cfg_pkg::lane_cnt_t vl
);

	// Lane count of a register filled with single-byte elements
	localparam vmask_cfg_pkg::lane_cnt_t FULL_LANES =
		vmask_cfg_pkg::lane_cnt_t'(vmask_cfg_pkg::VEC_BYTES);

	// Capacity is the register bytes divided by the element bytes
	// Element bytes are a power of two, so the divide is a right shift
	always_comb begin
		max_lanes = FULL_LANES >> esz;
	end

	// Requests beyond the capacity are cut back to it
	// A shorter request passes unchanged, zero included
	always_comb begin
		if (req_len > max_lanes) begin
			vl = max_lanes;
		end else begin
			vl = req_len;
		end
	end

endmodule

`default_nettype wire

// ==== logic/vmask_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

// ======================================================================
// Lane mask generator
// ======================================================================

module vmask_gen (
	input  vmask_cfg_pkg::lane_cnt_t vl,
	input  vmask_cfg_pkg::esz_t      esz,
	output vmask_cfg_pkg::mask_t     mask
);

	localparam int VB = vmask_cfg_pkg::VEC_BYTES;

	// One bit per lane, lanes below vl set
	vmask_cfg_pkg::mask_t therm;

	// Thermometer of the active lanes
	// Comparing each lane number avoids the 65-bit shift of a one
	always_comb begin
		for (int i = 0; i < VB; i++) begin
			therm[i] = (vmask_cfg_pkg::lane_cnt_t'(i) < vl);
		end
	end

	// Lane i lands on byte i times the element size
	// Only the lowest byte bit of an element is set, the rest stay clear
	// Lanes past the capacity are never set because vl was clamped at SETVL
	always_comb begin
		mask = '0;
		case (esz)
		2'd0: begin
			mask = therm;
		end
		2'd1: begin
			for (int i = 0; i < VB / 2; i++) begin
				mask[i * 2] = therm[i];
			end
		end
		2'd2: begin
			for (int i = 0; i < VB / 4; i++) begin
				mask[i * 4] = therm[i];
			end
		end
		default: begin
			// 8-byte elements
			for (int i = 0; i < VB / 8; i++) begin
				mask[i * 8] = therm[i];
			end
		end
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/mask_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

// ======================================================================
// Mask register file, two read ports and one write port
// ======================================================================

module mask_regfile #(
	parameter int NUM_MREGS = 8
) (
	input  logic                     clk,
	input  logic                     arst_n,
	input  vmask_cfg_pkg::mreg_idx_t rd_idx_a,
	input  vmask_cfg_pkg::mreg_idx_t rd_idx_b,
	output vmask_cfg_pkg::mask_t     rd_mask_a,
	output vmask_cfg_pkg::mask_t     rd_mask_b,
	input  logic                     wr_en,
	input  vmask_cfg_pkg::mreg_idx_t wr_idx,
	input  vmask_cfg_pkg::mask_t     wr_mask
);

	vmask_cfg_pkg::mask_t regs [NUM_MREGS];

	// Writes to an index past the last register are dropped
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_MREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (int'(wr_idx) < NUM_MREGS)) begin
			regs[wr_idx] <= wr_mask;
		end
	end

	// Reads are combinational
	// A write at this edge is seen by the op of the next cycle
	// Missing registers read as an empty mask
	always_comb begin
		rd_mask_a = '0;
		rd_mask_b = '0;
		if (int'(rd_idx_a) < NUM_MREGS) begin
			rd_mask_a = regs[rd_idx_a];
		end
		if (int'(rd_idx_b) < NUM_MREGS) begin
			rd_mask_b = regs[rd_idx_b];
		end
	end

endmodule

`default_nettype wire

// ==== logic/mask_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

// ======================================================================
// Mask logic and population count
// ======================================================================

module mask_alu (
	input  vmask_op_pkg::opcode_t    opcode,
	input  vmask_cfg_pkg::mask_t     mask_a,
	input  vmask_cfg_pkg::mask_t     mask_b,
	output vmask_cfg_pkg::mask_t     mask,
	output vmask_cfg_pkg::lane_cnt_t pop
);

	// Bitwise combine of the two source masks
	// Opcodes that are not combines give an empty mask
	always_comb begin
		case (opcode)
		vmask_op_pkg::OP_MAND: begin
			mask = mask_a & mask_b;
		end
		vmask_op_pkg::OP_MOR: begin
			mask = mask_a | mask_b;
		end
		vmask_op_pkg::OP_MXOR: begin
			mask = mask_a ^ mask_b;
		end
		vmask_op_pkg::OP_MANDN: begin
			// Clear from A every bit that B has set
			mask = mask_a & ~mask_b;
		end
		default: begin
			mask = '0;
		end
		endcase
	end

	// Set bits of the first source, 0 to 64
	// The adder chain is left for synthesis to rebalance into a tree
	always_comb begin
		pop = '0;
		for (int i = 0; i < vmask_cfg_pkg::VEC_BYTES; i++) begin
			pop = pop + vmask_cfg_pkg::lane_cnt_t'(mask_a[i]);
		end
	end

endmodule

`default_nettype wire

// ==== logic/vmask_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

// ======================================================================
// Vector mask unit top level
// ======================================================================

module vmask_unit #(
	parameter int NUM_MREGS = 8
) (
	input  logic                     clk,
	input  logic                     arst_n,
	input  vmask_op_pkg::op_t        op,
	output vmask_op_pkg::res_t       res,
	output vmask_cfg_pkg::lane_cnt_t vl,
	output vmask_cfg_pkg::esz_t      esz
);

	// Clamped length for a SETVL in this cycle
	vmask_cfg_pkg::lane_cnt_t calc_vl;
	// Lane mask from the stored configuration
	vmask_cfg_pkg::mask_t     gen_mask;
	// Register file read data for rs1 and rs2
	vmask_cfg_pkg::mask_t     rd_mask_a;
	vmask_cfg_pkg::mask_t     rd_mask_b;
	// Combine and count results
	vmask_cfg_pkg::mask_t     alu_mask;
	vmask_cfg_pkg::lane_cnt_t alu_pop;

	// Decode outputs
	logic                     wr_en;
	logic                     cfg_we;
	vmask_cfg_pkg::mask_t     wb_mask;
	vmask_op_pkg::res_t       res_nxt;

	// Result register for the op sampled at the last edge
	vmask_op_pkg::res_t       res_q;

	// ==================================================================
	// Datapath blocks
	// ==================================================================

	// The capacity output is only needed inside the clamp
	vlen_calc u_vlen_calc (
		.esz       (op.esz),
		.req_len   (op.req_len),
		.max_lanes (),
		.vl        (calc_vl)
	);

	// SETVMASK sees the configuration as it stands when sampled
	vmask_gen u_vmask_gen (
		.vl   (vl),
		.esz  (esz),
		.mask (gen_mask)
	);

	mask_regfile #(
		.NUM_MREGS (NUM_MREGS)
	) u_mask_regfile (
		.clk       (clk),
		.arst_n    (arst_n),
		.rd_idx_a  (op.rs1),
		.rd_idx_b  (op.rs2),
		.rd_mask_a (rd_mask_a),
		.rd_mask_b (rd_mask_b),
		.wr_en     (wr_en),
		.wr_idx    (op.rd),
		.wr_mask   (wb_mask)
	);

	mask_alu u_mask_alu (
		.opcode (op.opcode),
		.mask_a (rd_mask_a),
		.mask_b (rd_mask_b),
		.mask   (alu_mask),
		.pop    (alu_pop)
	);

	// ==================================================================
	// Decode and write-back
	// ==================================================================

	// Write-back data is the generated mask for SETVMASK, else the combine
	assign wb_mask = (op.opcode == vmask_op_pkg::OP_SETVMASK) ? gen_mask : alu_mask;

	// Unknown opcodes still complete, with empty fields and no write
	always_comb begin
		res_nxt        = '0;
		res_nxt.valid  = op.valid;
		res_nxt.opcode = op.opcode;
		wr_en          = 1'b0;
		cfg_we         = 1'b0;
		case (op.opcode)
		vmask_op_pkg::OP_SETVL: begin
			res_nxt.count = calc_vl;
			cfg_we        = op.valid;
		end
		vmask_op_pkg::OP_SETVMASK,
		vmask_op_pkg::OP_MAND,
		vmask_op_pkg::OP_MOR,
		vmask_op_pkg::OP_MXOR,
		vmask_op_pkg::OP_MANDN: begin
			res_nxt.mask = wb_mask;
			wr_en        = op.valid;
		end
		vmask_op_pkg::OP_MPOP: begin
			res_nxt.count = alu_pop;
		end
		default: begin
		end
		endcase
	end

	// Configuration register, updated at the edge that samples SETVL
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			vl  <= '0;
			esz <= '0;
		end else if (cfg_we) begin
			vl  <= calc_vl;
			esz <= op.esz;
		end
	end

	// One result per valid op, one cycle later
	// An idle slot loads a result with valid low
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			res_q <= '0;
		end else begin
			res_q <= res_nxt;
		end
	end

	assign res = res_q;

endmodule

`default_nettype wire

// ==== include/vmask_model.svh ====
`ifndef VMASK_MODEL_SVH
`define VMASK_MODEL_SVH

// ======================================================================
// Reference functions for the mask unit checks
// ======================================================================

// Smaller of the request and the lanes that fit the element size
function automatic vmask_cfg_pkg::lane_cnt_t model_clamp(
	input vmask_cfg_pkg::lane_cnt_t req_len,
	input vmask_cfg_pkg::esz_t      esz
);
	vmask_cfg_pkg::lane_cnt_t cap;
	cap = vmask_cfg_pkg::lane_cnt_t'(vmask_cfg_pkg::VEC_BYTES >> esz);
	return (req_len < cap) ? req_len : cap;
endfunction

// Bit i shifted by esz is set for every element i below vl
// Positions off the end of the register are ignored
function automatic vmask_cfg_pkg::mask_t model_mask(
	input vmask_cfg_pkg::lane_cnt_t vl,
	input vmask_cfg_pkg::esz_t      esz
);
	vmask_cfg_pkg::mask_t m;
	int pos;
	m = '0;
	for (int i = 0; i < int'(vl); i++) begin
		pos = i << esz;
		if (pos < vmask_cfg_pkg::VEC_BYTES) begin
			m[pos] = 1'b1;
		end
	end
	return m;
endfunction

// Number of set bits in a mask
function automatic vmask_cfg_pkg::lane_cnt_t model_pop(
	input vmask_cfg_pkg::mask_t m
);
	int n;
	n = 0;
	foreach (m[i]) begin
		if (m[i]) begin
			n++;
		end
	end
	return vmask_cfg_pkg::lane_cnt_t'(n);
endfunction

`endif

// ==== verif/tb_vmask_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_vmask_unit;

	localparam int NUM_MREGS      = 8;
	localparam int RESET_CYCLES   = 4;
	localparam int RAND_OPS       = 2000;
	// Upper bound on the slots used by the directed part
	localparam int DIRECTED_SLOTS = 48;
	// Each random op may be preceded by one idle slot, hence the factor of two
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + DIRECTED_SLOTS + 2 * RAND_OPS + 20;

	logic                     clk = 1'b0;
	logic                     arst_n;
	vmask_op_pkg::op_t        op;
	vmask_op_pkg::res_t       res;
	vmask_cfg_pkg::lane_cnt_t dut_vl;
	vmask_cfg_pkg::esz_t      dut_esz;

	// Reference state, advanced in issue order
	vmask_cfg_pkg::lane_cnt_t model_vl;
	vmask_cfg_pkg::esz_t      model_esz;
	vmask_cfg_pkg::mask_t     model_regs [NUM_MREGS];

	// Expected outputs, one entry per issued slot
	vmask_op_pkg::res_t       exp_res_q [$];
	vmask_cfg_pkg::lane_cnt_t exp_vl_q [$];
	vmask_cfg_pkg::esz_t      exp_esz_q [$];

	logic [31:0]              lfsr_state = 32'd86361;
	int                       mismatch_errs = 0;
	int                       protocol_errs = 0;
	int                       cycle_cnt = 0;

	`include "vmask_model.svh"

	vmask_unit #(
		.NUM_MREGS (NUM_MREGS)
	) u_dut (
		.clk    (clk),
		.arst_n (arst_n),
		.op     (op),
		.res    (res),
		.vl     (dut_vl),
		.esz    (dut_esz)
	);

	always #10 clk = ~clk;

	// Hard stop in case a wait never returns
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("test failed");
			$finish;
		end
	end

	// ==================================================================
	// Random source
	// ==================================================================

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end
		return s >> 1;
	endfunction

	// One LFSR step per bit taken, oldest bit ends up on top
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	function automatic vmask_op_pkg::op_t random_op(input logic valid);
		vmask_op_pkg::op_t o;
		o.valid   = valid;
		o.opcode  = vmask_op_pkg::opcode_t'(rand_bits(3));
		o.rd      = vmask_cfg_pkg::mreg_idx_t'(rand_bits(3));
		o.rs1     = vmask_cfg_pkg::mreg_idx_t'(rand_bits(3));
		o.rs2     = vmask_cfg_pkg::mreg_idx_t'(rand_bits(3));
		o.esz     = vmask_cfg_pkg::esz_t'(rand_bits(2));
		// Fold 0..127 onto 0..64 so over-long requests still appear
		o.req_len = vmask_cfg_pkg::lane_cnt_t'(rand_bits(7) % 32'd65);
		return o;
	endfunction

	function automatic vmask_op_pkg::op_t build_op(
		input vmask_op_pkg::opcode_t    opcode,
		input vmask_cfg_pkg::mreg_idx_t rd,
		input vmask_cfg_pkg::mreg_idx_t rs1,
		input vmask_cfg_pkg::mreg_idx_t rs2,
		input vmask_cfg_pkg::esz_t      esz,
		input vmask_cfg_pkg::lane_cnt_t req_len
	);
		vmask_op_pkg::op_t o;
		o.valid   = 1'b1;
		o.opcode  = opcode;
		o.rd      = rd;
		o.rs1     = rs1;
		o.rs2     = rs2;
		o.esz     = esz;
		o.req_len = req_len;
		return o;
	endfunction

	// ==================================================================
	// Compare tasks
	// ==================================================================

	task automatic check_mask(input string what, input vmask_cfg_pkg::mask_t got,
			input vmask_cfg_pkg::mask_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
			mismatch_errs++;
		end
	endtask

	task automatic check_count(input string what, input vmask_cfg_pkg::lane_cnt_t got,
			input vmask_cfg_pkg::lane_cnt_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
			mismatch_errs++;
		end
	endtask

	task automatic check_opcode(input vmask_op_pkg::opcode_t got,
			input vmask_op_pkg::opcode_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: res.opcode got %0d expected %0d", $time, got, exp);
			mismatch_errs++;
		end
	endtask

	task automatic check_cfg(input vmask_cfg_pkg::lane_cnt_t got_vl,
			input vmask_cfg_pkg::esz_t got_esz, input vmask_cfg_pkg::lane_cnt_t exp_vl,
			input vmask_cfg_pkg::esz_t exp_esz);
		if (got_vl !== exp_vl || got_esz !== exp_esz) begin
			$display("mismatch at %0t: config got vl %0d esz %0d expected vl %0d esz %0d",
				$time, got_vl, got_esz, exp_vl, exp_esz);
			mismatch_errs++;
		end
	endtask

	// ==================================================================
	// Model and per-cycle flow
	// ==================================================================

	// Works out the result of one slot and advances the model state
	task automatic predict(input vmask_op_pkg::op_t o);
		vmask_op_pkg::res_t   e;
		vmask_cfg_pkg::mask_t a;
		vmask_cfg_pkg::mask_t b;
		logic                 writes;
		e        = '0;
		e.valid  = o.valid;
		e.opcode = o.opcode;
		a        = model_regs[o.rs1];
		b        = model_regs[o.rs2];
		writes   = 1'b0;
		if (o.valid) begin
			case (o.opcode)
			vmask_op_pkg::OP_SETVL: begin
				e.count   = model_clamp(o.req_len, o.esz);
				model_vl  = e.count;
				model_esz = o.esz;
			end
			vmask_op_pkg::OP_SETVMASK: begin
				// Built from the configuration before this op
				e.mask = model_mask(model_vl, model_esz);
				writes = 1'b1;
			end
			vmask_op_pkg::OP_MAND: begin
				e.mask = a & b;
				writes = 1'b1;
			end
			vmask_op_pkg::OP_MOR: begin
				e.mask = a | b;
				writes = 1'b1;
			end
			vmask_op_pkg::OP_MXOR: begin
				e.mask = a ^ b;
				writes = 1'b1;
			end
			vmask_op_pkg::OP_MANDN: begin
				e.mask = a & ~b;
				writes = 1'b1;
			end
			vmask_op_pkg::OP_MPOP: begin
				e.count = model_pop(a);
			end
			default: begin
			end
			endcase
			if (writes) begin
				model_regs[o.rd] = e.mask;
			end
		end
		exp_res_q.push_back(e);
		exp_vl_q.push_back(model_vl);
		exp_esz_q.push_back(model_esz);
	endtask

	// Runs 2 ns after the edge that sampled the op, outputs are settled
	task automatic check_result();
		vmask_op_pkg::res_t       e;
		vmask_cfg_pkg::lane_cnt_t evl;
		vmask_cfg_pkg::esz_t      eesz;
		e    = exp_res_q.pop_front();
		evl  = exp_vl_q.pop_front();
		eesz = exp_esz_q.pop_front();
		if (e.valid && !res.valid) begin
			$display("missing result: opcode %0d gave no res.valid at %0t", e.opcode, $time);
			protocol_errs++;
		end else if (!e.valid && res.valid) begin
			$display("extra result: res.valid high at %0t after an idle cycle", $time);
			protocol_errs++;
		end else if (e.valid) begin
			check_opcode(res.opcode, e.opcode);
			check_mask("res.mask", res.mask, e.mask);
			check_count("res.count", res.count, e.count);
		end
		check_cfg(dut_vl, dut_esz, evl, eesz);
	endtask

	task automatic step(input vmask_op_pkg::op_t o);
		op = o;
		predict(o);
		@(posedge clk);
		#2;
		check_result();
	endtask

	initial begin
		arst_n    = 1'b0;
		op        = '0;
		model_vl  = '0;
		model_esz = '0;
		for (int i = 0; i < NUM_MREGS; i++) begin
			model_regs[i] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		arst_n = 1'b1;

		// Reset state, then every register must count zero
		if (res.valid) begin
			$display("res.valid is high right after reset at %0t", $time);
			protocol_errs++;
		end
		check_cfg(dut_vl, dut_esz, '0, '0);
		step(random_op(1'b0));
		step(random_op(1'b0));
		for (int r = 0; r < NUM_MREGS; r++) begin
			step(build_op(vmask_op_pkg::OP_MPOP, 3'd0, 3'(r), 3'd0, 2'd0, 7'd0));
		end

		// Full and short lengths for each element size, MPOP then equals vl
		for (int e = 0; e < 4; e++) begin
			step(build_op(vmask_op_pkg::OP_SETVL, 3'd0, 3'd0, 3'd0, 2'(e), 7'd64));
			step(build_op(vmask_op_pkg::OP_SETVMASK, 3'(e), 3'd0, 3'd0, 2'd0, 7'd0));
			step(build_op(vmask_op_pkg::OP_MPOP, 3'd0, 3'(e), 3'd0, 2'd0, 7'd0));
			step(build_op(vmask_op_pkg::OP_SETVL, 3'd0, 3'd0, 3'd0, 2'(e), 7'd5));
			step(build_op(vmask_op_pkg::OP_SETVMASK, 3'(e + 4), 3'd0, 3'd0, 2'd0, 7'd0));
			step(build_op(vmask_op_pkg::OP_MPOP, 3'd0, 3'(e + 4), 3'd0, 2'd0, 7'd0));
		end

		// Back-to-back chain through one register, rd equal to rs1
		step(build_op(vmask_op_pkg::OP_MAND, 3'd1, 3'd0, 3'd4, 2'd0, 7'd0));
		step(build_op(vmask_op_pkg::OP_MOR, 3'd1, 3'd1, 3'd7, 2'd0, 7'd0));
		step(build_op(vmask_op_pkg::OP_MXOR, 3'd1, 3'd1, 3'd3, 2'd0, 7'd0));
		step(build_op(vmask_op_pkg::OP_MANDN, 3'd6, 3'd1, 3'd2, 2'd0, 7'd0));
		step(build_op(vmask_op_pkg::OP_MPOP, 3'd0, 3'd6, 3'd0, 2'd0, 7'd0));

		// Random ops at full rate, now and then one idle slot in between
		for (int n = 0; n < RAND_OPS; n++) begin
			if (rand_bits(3) == 32'd0) begin
				step(random_op(1'b0));
			end
			step(random_op(1'b1));
		end

		$display("errors: %0d mismatch, %0d protocol", mismatch_errs, protocol_errs);
		if (mismatch_errs == 0 && protocol_errs == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
logic/vmask_cfg_pkg.sv
logic/vmask_op_pkg.sv
logic/vlen_calc.sv
logic/vmask_gen.sv
logic/mask_regfile.sv
logic/mask_alu.sv
logic/vmask_unit.sv
verif/tb_vmask_unit.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.
# Exit status is 0 only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
	--top-module tb_vmask_unit \
	-f files.f \
	-o sim_vmask_unit \
	|| { echo "build failed"; exit 1; }

out=$(./obj_dir/sim_vmask_unit) || { echo "$out"; echo "simulation did not run"; exit 1; }
echo "$out"
echo "$out" | grep -qx "test passed" && exit 0 || exit 1
